/* logic/fetch_pkg.sv */
// Fetch path package with the shared widths, types and cache bus constants
package fetch_pkg;

    ////////////////////
    // Block geometry
    ////////////////////

    localparam int FETCH_SLOTS = 4;                 // Instructions per fetch block

    typedef logic [31:0] vaddr_t;                   // Virtual address
    typedef logic [31:0] inst_t;                    // One instruction word

    // Slot 0 sits in the low bits
    typedef logic [FETCH_SLOTS*$bits(inst_t)-1:0] fetch_block_t;

    typedef logic [FETCH_SLOTS-1:0]           slot_mask_t;   // One enable per slot
    typedef logic [$clog2(FETCH_SLOTS)-1:0]   slot_idx_t;    // Slot within a block
    typedef logic [$clog2(FETCH_SLOTS+1)-1:0] inst_num_t;    // Count of enabled slots

    ////////////////////
    // Cache bus codes
    ////////////////////

    localparam logic [1:0] INST_SIZE_BLOCK = 2'b11; // Four words, 16 bytes per transfer

endpackage

/* logic/pc_register.sv */
// PC register, holds the fetch address, applies redirects and drives the cache request
module pc_register
    import fetch_pkg::*;
#(
    parameter vaddr_t RESET_PC = 32'hbfc0_0000
) (
    input  logic       clk,
    input  logic       rst_i,
    input  logic       stop_fetch_i,
    input  logic       inst_index_ok_i,
    input  logic       req_room_i,
    input  logic       pred_hit_i,
    input  slot_idx_t  pred_slot_i,
    input  vaddr_t     pred_dest_i,
    input  logic       sba_flush_i,
    input  vaddr_t     sba_pc_i,
    input  vaddr_t     sba_dest_i,
    input  logic       sba_take_i,
    input  logic       exc_occur_i,
    input  vaddr_t     exc_pc_i,
    output logic       inst_req_o,
    output vaddr_t     inst_index_o,
    output logic [1:0] inst_size_o,
    output vaddr_t     fetch_pc_o,
    output slot_mask_t start_mask_o,
    output logic       req_accept_o,
    output logic       cancel_o
);

    vaddr_t     pc_q;
    vaddr_t     pc_next;
    vaddr_t     block_base;
    slot_idx_t  start_slot;
    logic       pred_use;
    logic       run_q;      // Set from the first cycle out of reset
    logic       stop_q;

    ////////////////////
    // Block decode
    ////////////////////

    assign block_base   = {pc_q[31:4], 4'b0000};
    assign start_slot   = pc_q[3:2];                        // Word offset
    assign start_mask_o = slot_mask_t'(4'b1111 << start_slot);

    // A hit before the start slot belongs to code we skip
    assign pred_use = pred_hit_i & start_mask_o[pred_slot_i];

    ////////////////////
    // Cache request
    ////////////////////

    // Stop holds off one more cycle after the queue releases it
    assign inst_req_o   = run_q & ~stop_fetch_i & ~stop_q & req_room_i;
    assign req_accept_o = inst_req_o & inst_index_ok_i;
    assign inst_index_o = block_base;
    assign inst_size_o  = INST_SIZE_BLOCK;
    assign fetch_pc_o   = pc_q;

    assign cancel_o = exc_occur_i | sba_flush_i;

    // Exception first, then branch resolution, then prediction
    always_comb begin
        if (exc_occur_i) begin
            pc_next = exc_pc_i;
        end else if (sba_flush_i) begin
            pc_next = sba_take_i ? sba_dest_i : sba_pc_i + 32'd4;
        end else if (pred_use) begin
            pc_next = pred_dest_i;
        end else begin
            pc_next = block_base + 32'd16;
        end
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            pc_q   <= RESET_PC;
            run_q  <= 1'b0;
            stop_q <= 1'b0;
        end else begin
            run_q  <= 1'b1;
            stop_q <= stop_fetch_i;
            if (cancel_o || req_accept_o) begin
                pc_q <= pc_next;
            end
        end
    end

endmodule

/* logic/branch_target_buffer.sv */
// Branch target buffer, direct mapped, one taken branch per fetch block
module branch_target_buffer
    import fetch_pkg::*;
#(
    parameter int BTB_ENTRIES = 16
) (
    input  logic      clk,
    input  logic      rst_i,
    input  vaddr_t    fetch_pc_i,
    input  logic      sba_flush_i,
    input  vaddr_t    sba_pc_i,
    input  vaddr_t    sba_dest_i,
    input  logic      sba_take_i,
    output logic      pred_hit_o,
    output slot_idx_t pred_slot_o,
    output vaddr_t    pred_dest_o
);

    localparam int IDX_W = $clog2(BTB_ENTRIES);
    localparam int TAG_W = $bits(vaddr_t) - 4 - IDX_W;

    typedef logic [IDX_W-1:0] btb_idx_t;
    typedef logic [TAG_W-1:0] btb_tag_t;

    logic [BTB_ENTRIES-1:0] valid_q;
    btb_tag_t               tag_q    [BTB_ENTRIES];
    slot_idx_t              slot_q   [BTB_ENTRIES];
    vaddr_t                 target_q [BTB_ENTRIES];

    btb_idx_t rd_idx;
    btb_tag_t rd_tag;
    btb_idx_t wr_idx;
    btb_tag_t wr_tag;
    logic     wr_tag_hit;

    ////////////////////
    // Lookup
    ////////////////////

    assign rd_idx = fetch_pc_i[4 +: IDX_W];                 // Block address bits
    assign rd_tag = fetch_pc_i[$bits(vaddr_t)-1 -: TAG_W];

    assign pred_hit_o  = valid_q[rd_idx] && (tag_q[rd_idx] == rd_tag);
    assign pred_slot_o = slot_q[rd_idx];
    assign pred_dest_o = target_q[rd_idx];

    ////////////////////
    // Training
    ////////////////////

    assign wr_idx     = sba_pc_i[4 +: IDX_W];
    assign wr_tag     = sba_pc_i[$bits(vaddr_t)-1 -: TAG_W];
    assign wr_tag_hit = valid_q[wr_idx] && (tag_q[wr_idx] == wr_tag);

    always_ff @(posedge clk) begin
        if (rst_i) begin
            valid_q <= '0;
        end else if (sba_flush_i) begin
            if (sba_take_i) begin
                valid_q[wr_idx] <= 1'b1;
            end else if (wr_tag_hit) begin
                valid_q[wr_idx] <= 1'b0;    // Branch went the other way
            end
        end
    end

    always_ff @(posedge clk) begin
        if (sba_flush_i && sba_take_i) begin
            tag_q[wr_idx]    <= wr_tag;
            slot_q[wr_idx]   <= sba_pc_i[3:2];
            target_q[wr_idx] <= sba_dest_i;
        end
    end

endmodule

/* logic/fetch_request_stage.sv */
// Fetch request stage, in-order table of accepted blocks waiting for cache data
module fetch_request_stage
    import fetch_pkg::*;
#(
    parameter int MAX_INFLIGHT = 2
) (
    input  logic       clk,
    input  logic       rst_i,
    input  logic       req_accept_i,
    input  vaddr_t     fetch_pc_i,
    input  slot_mask_t start_mask_i,
    input  logic       pred_hit_i,
    input  slot_idx_t  pred_slot_i,
    input  vaddr_t     pred_dest_i,
    input  logic       cancel_i,
    input  logic       inst_data_ok_i,
    output logic       req_room_o,
    output logic       pop_o,
    output logic       pop_cancelled_o,
    output vaddr_t     pop_pc_o,
    output slot_mask_t pop_enable_o,
    output slot_mask_t pop_take_o,
    output vaddr_t     pop_dest_o
);

    localparam int PTR_W = (MAX_INFLIGHT > 1) ? $clog2(MAX_INFLIGHT) : 1;
    localparam int CNT_W = $clog2(MAX_INFLIGHT + 1);

    typedef logic [PTR_W-1:0] ptr_t;
    typedef logic [CNT_W-1:0] cnt_t;

    vaddr_t                  ent_pc     [MAX_INFLIGHT];
    slot_mask_t              ent_enable [MAX_INFLIGHT];
    slot_mask_t              ent_take   [MAX_INFLIGHT];
    vaddr_t                  ent_dest   [MAX_INFLIGHT];
    logic [MAX_INFLIGHT-1:0] ent_cancel;

    ptr_t       wr_ptr;
    ptr_t       rd_ptr;
    cnt_t       count;
    logic       pred_use;
    slot_mask_t push_enable;
    slot_mask_t push_take;

    function automatic ptr_t next_ptr(ptr_t p);
        return (p == ptr_t'(MAX_INFLIGHT - 1)) ? '0 : p + ptr_t'(1);
    endfunction

    // Cut the block after a predicted taken branch
    always_comb begin
        pred_use    = pred_hit_i & start_mask_i[pred_slot_i];
        push_enable = start_mask_i;
        push_take   = '0;
        if (pred_use) begin
            for (int i = 0; i < FETCH_SLOTS; i++) begin
                if (i > int'(pred_slot_i)) begin
                    push_enable[i] = 1'b0;
                end
            end
            push_take[pred_slot_i] = 1'b1;
        end
    end

    assign req_room_o = (count != cnt_t'(MAX_INFLIGHT));
    assign pop_o      = inst_data_ok_i && (count != '0);

    // A redirect in the data cycle kills the returning block too
    assign pop_cancelled_o = ent_cancel[rd_ptr] | cancel_i;
    assign pop_pc_o        = ent_pc[rd_ptr];
    assign pop_enable_o    = ent_enable[rd_ptr];
    assign pop_take_o      = ent_take[rd_ptr];
    assign pop_dest_o      = ent_dest[rd_ptr];

    always_ff @(posedge clk) begin
        if (rst_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (req_accept_i) wr_ptr <= next_ptr(wr_ptr);
            if (pop_o) rd_ptr <= next_ptr(rd_ptr);
            count <= count + cnt_t'(req_accept_i) - cnt_t'(pop_o);
        end
    end

    always_ff @(posedge clk) begin
        if (cancel_i) ent_cancel <= '1;             // Mark everything in flight
        if (req_accept_i) begin
            ent_pc[wr_ptr]     <= fetch_pc_i;
            ent_enable[wr_ptr] <= push_enable;
            ent_take[wr_ptr]   <= push_take;
            ent_dest[wr_ptr]   <= pred_dest_i;
            ent_cancel[wr_ptr] <= cancel_i;
        end
    end

endmodule

/* logic/fetch_response_stage.sv */
// Fetch response stage, pairs cache data with its block and presents it to the queue
module fetch_response_stage
    import fetch_pkg::*;
(
    input  logic         clk,
    input  logic         rst_i,
    input  logic         pop_i,
    input  logic         pop_cancelled_i,
    input  vaddr_t       pop_pc_i,
    input  slot_mask_t   pop_enable_i,
    input  slot_mask_t   pop_take_i,
    input  vaddr_t       pop_dest_i,
    input  fetch_block_t inst_rdata_i,
    output logic         valid_o,
    output vaddr_t       base_pc_o,
    output slot_mask_t   inst_enable_o,
    output fetch_block_t inst_o,
    output inst_num_t    inst_num_o,
    output logic [FETCH_SLOTS-1:0] pred_take_o,
    output vaddr_t       pred_dest_o
);

    inst_num_t enable_cnt;

    always_comb begin
        enable_cnt = '0;
        for (int i = 0; i < FETCH_SLOTS; i++) begin
            enable_cnt = enable_cnt + inst_num_t'(pop_enable_i[i]);
        end
    end

    ////////////////////
    // Output register
    ////////////////////

    always_ff @(posedge clk) begin
        if (rst_i) begin
            valid_o <= 1'b0;
        end else begin
            valid_o <= pop_i & ~pop_cancelled_i;     // Single cycle pulse
        end
    end

    always_ff @(posedge clk) begin
        if (pop_i) begin
            base_pc_o     <= {pop_pc_i[31:4], 4'b0000};
            inst_enable_o <= pop_enable_i;
            inst_o        <= inst_rdata_i;
            inst_num_o    <= enable_cnt;
            pred_take_o   <= pop_take_i;
            pred_dest_o   <= pop_dest_i;
        end
    end

endmodule

/* logic/fetch_unit.sv */
// Fetch unit top level, connects PC, branch target buffer, request and response stages
module fetch_unit
    import fetch_pkg::*;
#(
    parameter vaddr_t RESET_PC     = 32'hbfc0_0000,
    parameter int     BTB_ENTRIES  = 16,
    parameter int     MAX_INFLIGHT = 2
) (
    input  logic         clk,
    input  logic         rst_i,

    // Cache bus
    output logic         inst_req_o,
    output vaddr_t       inst_index_o,
    output logic [1:0]   inst_size_o,
    input  logic         inst_index_ok_i,
    input  logic         inst_data_ok_i,
    input  fetch_block_t inst_rdata_i,

    // Instruction queue
    input  logic         stop_fetch_i,
    output logic         valid_o,
    output vaddr_t       base_pc_o,
    output slot_mask_t   inst_enable_o,
    output fetch_block_t inst_o,
    output inst_num_t    inst_num_o,
    output slot_mask_t   pred_take_o,
    output vaddr_t       pred_dest_o,

    // Branch resolution
    input  logic         sba_flush_i,
    input  vaddr_t       sba_pc_i,
    input  vaddr_t       sba_dest_i,
    input  logic         sba_take_i,

    // Exception entry
    input  logic         exc_occur_i,
    input  vaddr_t       exc_pc_i
);

    vaddr_t     fetch_pc;
    logic       pred_hit;
    slot_idx_t  pred_slot;
    vaddr_t     pred_dest;
    slot_mask_t start_mask;
    logic       req_accept;
    logic       req_room;
    logic       cancel;

    logic       pop;
    logic       pop_cancelled;
    vaddr_t     pop_pc;
    slot_mask_t pop_enable;
    slot_mask_t pop_take;
    vaddr_t     pop_dest;

    pc_register #(
        .RESET_PC        (RESET_PC)
    ) u_pc_register (
        .clk             (clk),
        .rst_i           (rst_i),
        .stop_fetch_i    (stop_fetch_i),
        .inst_index_ok_i (inst_index_ok_i),
        .req_room_i      (req_room),
        .pred_hit_i      (pred_hit),
        .pred_slot_i     (pred_slot),
        .pred_dest_i     (pred_dest),
        .sba_flush_i     (sba_flush_i),
        .sba_pc_i        (sba_pc_i),
        .sba_dest_i      (sba_dest_i),
        .sba_take_i      (sba_take_i),
        .exc_occur_i     (exc_occur_i),
        .exc_pc_i        (exc_pc_i),
        .inst_req_o      (inst_req_o),
        .inst_index_o    (inst_index_o),
        .inst_size_o     (inst_size_o),
        .fetch_pc_o      (fetch_pc),
        .start_mask_o    (start_mask),
        .req_accept_o    (req_accept),
        .cancel_o        (cancel)
    );

    branch_target_buffer #(
        .BTB_ENTRIES     (BTB_ENTRIES)
    ) u_branch_target_buffer (
        .clk             (clk),
        .rst_i           (rst_i),
        .fetch_pc_i      (fetch_pc),
        .sba_flush_i     (sba_flush_i),
        .sba_pc_i        (sba_pc_i),
        .sba_dest_i      (sba_dest_i),
        .sba_take_i      (sba_take_i),
        .pred_hit_o      (pred_hit),
        .pred_slot_o     (pred_slot),
        .pred_dest_o     (pred_dest)
    );

    fetch_request_stage #(
        .MAX_INFLIGHT    (MAX_INFLIGHT)
    ) u_fetch_request_stage (
        .clk             (clk),
        .rst_i           (rst_i),
        .req_accept_i    (req_accept),
        .fetch_pc_i      (fetch_pc),
        .start_mask_i    (start_mask),
        .pred_hit_i      (pred_hit),
        .pred_slot_i     (pred_slot),
        .pred_dest_i     (pred_dest),
        .cancel_i        (cancel),
        .inst_data_ok_i  (inst_data_ok_i),
        .req_room_o      (req_room),
        .pop_o           (pop),
        .pop_cancelled_o (pop_cancelled),
        .pop_pc_o        (pop_pc),
        .pop_enable_o    (pop_enable),
        .pop_take_o      (pop_take),
        .pop_dest_o      (pop_dest)
    );

    fetch_response_stage u_fetch_response_stage (
        .clk             (clk),
        .rst_i           (rst_i),
        .pop_i           (pop),
        .pop_cancelled_i (pop_cancelled),
        .pop_pc_i        (pop_pc),
        .pop_enable_i    (pop_enable),
        .pop_take_i      (pop_take),
        .pop_dest_i      (pop_dest),
        .inst_rdata_i    (inst_rdata_i),
        .valid_o         (valid_o),
        .base_pc_o       (base_pc_o),
        .inst_enable_o   (inst_enable_o),
        .inst_o          (inst_o),
        .inst_num_o      (inst_num_o),
        .pred_take_o     (pred_take_o),
        .pred_dest_o     (pred_dest_o)
    );

endmodule

/* testbench/fetch_unit_checker.sv */
// Fetch unit checker, concurrent assertions on the top-level ports
module fetch_unit_checker
    import fetch_pkg::*;
(
    input logic       clk,
    input logic       rst_i,
    input logic       inst_req_o,
    input vaddr_t     inst_index_o,
    input logic       stop_fetch_i,
    input logic       valid_o,
    input slot_mask_t inst_enable_o
);
    timeunit 1ns;
    timeprecision 1ps;

    // A block handed to the queue carries at least one instruction
    enable_nonzero: assert property (@(posedge clk) disable iff (rst_i)
        valid_o |-> inst_enable_o != '0)
        else $error("valid_o with an empty enable mask");

    stop_holds_req: assert property (@(posedge clk) disable iff (rst_i)
        stop_fetch_i |=> !inst_req_o)
        else $error("inst_req_o high in the cycle after stop_fetch_i");

    index_aligned: assert property (@(posedge clk) disable iff (rst_i)
        inst_req_o |-> inst_index_o[3:0] == 4'b0000)
        else $error("inst_index_o not block aligned");

    no_valid_in_reset: assert property (@(posedge clk)
        rst_i |=> !valid_o)
        else $error("valid_o high during reset");

endmodule

bind fetch_unit fetch_unit_checker i_fetch_unit_checker (
    .clk           (clk),
    .rst_i         (rst_i),
    .inst_req_o    (inst_req_o),
    .inst_index_o  (inst_index_o),
    .stop_fetch_i  (stop_fetch_i),
    .valid_o       (valid_o),
    .inst_enable_o (inst_enable_o)
);

/* testbench/fetch_unit_tb.sv */
// Fetch unit testbench with cache model, reference model and comparison
module fetch_unit_tb;
    import fetch_pkg::*;
    timeunit 1ns;
    timeprecision 1ps;

    localparam vaddr_t RESET_PC    = 32'hbfc0_0000;
    localparam int     BTB_ENTRIES = 16;      // Index is pc[7:4], tag pc[31:8]
    localparam int     TEST_CYCLES = 240;     // Six tests, about 40 cycles each
    localparam inst_t  MEM_XOR     = 32'h5a5a_0000;

    logic clk = 1'b0;
    logic rst_i = 1'b1;
    logic inst_index_ok_i = 1'b0;
    logic inst_data_ok_i = 1'b0;
    fetch_block_t inst_rdata_i = '0;
    logic stop_fetch_i = 1'b0;
    logic sba_flush_i = 1'b0;
    vaddr_t sba_pc_i = '0;
    vaddr_t sba_dest_i = '0;
    logic sba_take_i = 1'b0;
    logic exc_occur_i = 1'b0;
    vaddr_t exc_pc_i = '0;

    logic inst_req_o;
    vaddr_t inst_index_o;
    logic [1:0] inst_size_o;
    logic valid_o;
    vaddr_t base_pc_o;
    slot_mask_t inst_enable_o;
    fetch_block_t inst_o;
    inst_num_t inst_num_o;
    slot_mask_t pred_take_o;
    vaddr_t pred_dest_o;

    integer seed = 32'h8eb3_ef00;
    int errors = 0;
    int blocks_seen = 0;
    int take_seen = 0;
    int accepts = 0;
    int cyc = 0;
    int ok_wait = 0;
    vaddr_t pend_addr[$];
    int pend_due[$];

    // Reference state
    vaddr_t model_pc;
    logic   m_valid [BTB_ENTRIES];
    logic [23:0] m_tag [BTB_ENTRIES];
    int     m_slot [BTB_ENTRIES];
    vaddr_t m_target [BTB_ENTRIES];

    fetch_unit #(
        .RESET_PC     (RESET_PC),
        .BTB_ENTRIES  (BTB_ENTRIES),
        .MAX_INFLIGHT (2)
    ) i_fetch_unit (.*);

    always #5 clk = ~clk;

    ////////////////////
    // Cache model
    ////////////////////

    always @(posedge clk) begin
        cyc = cyc + 1;
        if (rst_i) begin
            pend_addr.delete();
            pend_due.delete();
            ok_wait = 1;
        end else if (inst_req_o && inst_index_ok_i) begin
            assert (inst_size_o == INST_SIZE_BLOCK) else begin
                $display("FAILED %0t: inst_size_o %b, expected %b",
                         $time, inst_size_o, INST_SIZE_BLOCK);
                errors++;
            end
            accepts = accepts + 1;
            pend_addr.push_back(inst_index_o);
            pend_due.push_back(cyc + 1 + int'($unsigned($random(seed)) % 3));
            ok_wait = 1 + int'($unsigned($random(seed)) % 3);  // 0 to 2 cycles of wait
        end
    end

    always @(negedge clk) begin
        if (ok_wait > 0) ok_wait = ok_wait - 1;
        inst_index_ok_i <= (ok_wait == 0) && !rst_i;
        inst_data_ok_i  <= 1'b0;
        if (pend_due.size() > 0 && pend_due[0] <= cyc + 1) begin
            for (int i = 0; i < FETCH_SLOTS; i++) begin
                inst_rdata_i[i*32 +: 32] <= (pend_addr[0] + 32'(4 * i)) ^ MEM_XOR;
            end
            inst_data_ok_i <= 1'b1;
            void'(pend_addr.pop_front());
            void'(pend_due.pop_front());
        end
    end

    ////////////////////
    // Reference model
    ////////////////////

    function automatic void ref_block(input vaddr_t pc, output vaddr_t base,
                                      output slot_mask_t en, output slot_mask_t take,
                                      output vaddr_t dest, output fetch_block_t words,
                                      output vaddr_t next_pc);
        int start;
        int idx;
        logic hit;
        base  = {pc[31:4], 4'b0000};
        start = int'(pc[3:2]);
        idx   = int'(pc[7:4]);
        en    = '0;
        take  = '0;
        dest  = '0;
        for (int i = start; i < FETCH_SLOTS; i++) en[i] = 1'b1;
        hit = m_valid[idx] && (m_tag[idx] == pc[31:8]) && (m_slot[idx] >= start);
        next_pc = base + 32'd16;
        if (hit) begin
            for (int i = m_slot[idx] + 1; i < FETCH_SLOTS; i++) en[i] = 1'b0;
            take[m_slot[idx]] = 1'b1;
            dest    = m_target[idx];
            next_pc = m_target[idx];
        end
        for (int i = 0; i < FETCH_SLOTS; i++) begin
            words[i*32 +: 32] = (base + 32'(4 * i)) ^ MEM_XOR;
        end
    endfunction

    function automatic int count_ones(slot_mask_t m);
        int n;
        n = 0;
        for (int i = 0; i < FETCH_SLOTS; i++) n = n + int'(m[i]);
        return n;
    endfunction

    // Compare first, then apply a redirect sampled on the same edge
    always @(posedge clk) begin
        vaddr_t e_base;
        vaddr_t e_dest;
        vaddr_t e_next;
        slot_mask_t e_en;
        slot_mask_t e_take;
        fetch_block_t e_words;
        int idx;
        if (rst_i) begin
            model_pc = RESET_PC;
            for (int i = 0; i < BTB_ENTRIES; i++) m_valid[i] = 1'b0;
        end else begin
            if (valid_o) begin
                ref_block(model_pc, e_base, e_en, e_take, e_dest, e_words, e_next);
                assert (base_pc_o == e_base) else begin
                    $display("FAILED %0t: base_pc_o %h, expected %h", $time, base_pc_o, e_base);
                    errors++;
                end
                assert (inst_enable_o == e_en && inst_num_o == inst_num_t'(count_ones(e_en)))
                else begin
                    $display("FAILED %0t: enables %b num %0d, expected %b at %h",
                             $time, inst_enable_o, inst_num_o, e_en, e_base);
                    errors++;
                end
                assert (pred_take_o == e_take && (e_take == '0 || pred_dest_o == e_dest))
                else begin
                    $display("FAILED %0t: take %b dest %h, expected %b %h",
                             $time, pred_take_o, pred_dest_o, e_take, e_dest);
                    errors++;
                end
                assert (inst_o == e_words) else begin
                    $display("FAILED %0t: words %h, expected %h", $time, inst_o, e_words);
                    errors++;
                end
                if (pred_take_o != '0) take_seen++;
                model_pc = e_next;
                blocks_seen++;
            end
            if (sba_flush_i) begin
                idx = int'(sba_pc_i[7:4]);
                if (sba_take_i) begin
                    m_valid[idx]  = 1'b1;
                    m_tag[idx]    = sba_pc_i[31:8];
                    m_slot[idx]   = int'(sba_pc_i[3:2]);
                    m_target[idx] = sba_dest_i;
                end else if (m_valid[idx] && m_tag[idx] == sba_pc_i[31:8]) begin
                    m_valid[idx] = 1'b0;
                end
            end
            if (exc_occur_i) model_pc = exc_pc_i;
            else if (sba_flush_i) model_pc = sba_take_i ? sba_dest_i : sba_pc_i + 32'd4;
        end
    end

    ////////////////////
    // Stimulus
    ////////////////////

    task automatic wait_blocks(int n);
        int target;
        target = blocks_seen + n;
        while (blocks_seen < target) @(negedge clk);
    endtask

    task automatic redirect(logic exc, vaddr_t epc, logic flush, vaddr_t bpc,
                            vaddr_t bdest, logic take);
        @(negedge clk);
        exc_occur_i = exc;
        exc_pc_i    = epc;
        sba_flush_i = flush;
        sba_pc_i    = bpc;
        sba_dest_i  = bdest;
        sba_take_i  = take;
        @(negedge clk);
        exc_occur_i = 1'b0;
        sba_flush_i = 1'b0;
    endtask

    task automatic report(int num, string name);
        $display("test %0d %s: %0d blocks so far, %0d errors", num, name, blocks_seen, errors);
    endtask

    initial begin
        int acc0;
        int take0;
        repeat (16) @(negedge clk);
        rst_i = 1'b0;

        wait_blocks(6);
        report(1, "sequential fetch");

        redirect(1'b0, '0, 1'b1, 32'hbfc0_0104, '0, 1'b0);  // Lands on slot 2
        wait_blocks(3);
        report(2, "unaligned redirect");

        take0 = take_seen;
        redirect(1'b0, '0, 1'b1, 32'hbfc0_0204, 32'hbfc0_0400, 1'b1);
        wait_blocks(2);
        redirect(1'b1, 32'hbfc0_0200, 1'b0, '0, '0, 1'b0);
        wait_blocks(3);
        assert (take_seen > take0) else begin
            $display("No predicted block was seen after training the branch");
            errors++;
        end
        report(3, "prediction");

        take0 = take_seen;
        redirect(1'b0, '0, 1'b1, 32'hbfc0_0204, '0, 1'b0);
        wait_blocks(1);
        redirect(1'b1, 32'hbfc0_0200, 1'b0, '0, '0, 1'b0);
        wait_blocks(3);
        assert (take_seen == take0) else begin
            $display("The untrained branch was still predicted");
            errors++;
        end
        report(4, "untraining");

        wait_blocks(1);
        redirect(1'b1, 32'hbfc0_0800, 1'b1, 32'hbfc0_0304, 32'hbfc0_0500, 1'b1);
        wait_blocks(3);
        report(5, "exception priority");

        @(negedge clk);
        stop_fetch_i = 1'b1;
        repeat (2) @(negedge clk);
        acc0 = accepts;
        repeat (10) @(negedge clk);
        assert (accepts == acc0) else begin
            $display("FAILED %0t: request accepted while stop_fetch_i held", $time);
            errors++;
        end
        stop_fetch_i = 1'b0;
        wait_blocks(4);
        report(6, "stop");

        $display("6 tests, %0d blocks checked, %0d errors", blocks_seen, errors);
        if (errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

    // Watchdog
    initial begin
        repeat (16 + TEST_CYCLES * 20) @(posedge clk);
        $display("Timeout: the tests did not finish within %0d cycles", TEST_CYCLES * 20);
        $display("Simulation FAILED");
        $finish;
    end

endmodule

/* verilog.f */
logic/fetch_pkg.sv
logic/pc_register.sv
logic/branch_target_buffer.sv
logic/fetch_request_stage.sv
logic/fetch_response_stage.sv
logic/fetch_unit.sv
testbench/fetch_unit_checker.sv
testbench/fetch_unit_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the fetch unit testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wall \
    -f verilog.f \
    --top-module fetch_unit_tb \
    -o fetch_unit_sim

./obj_dir/fetch_unit_sim | tee sim.log

if grep -q "Simulation FAILED" sim.log; then
    exit 1
fi
exit 0
